// File: Makefile
# Verilator build and run for the eye tracker testbench
TOP   = eye_tracker_tb
BUILD = obj_dir

.PHONY: all lint clean

all: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): eye_tracker_top.f $(wildcard verilog/*.sv) test/eye_tracker_tb.sv
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f eye_tracker_top.f --Mdir $(BUILD)

lint:
	verilator --lint-only --timing -Wall --top-module eye_tracker_top -f eye_tracker_top.f

clean:
	rm -rf $(BUILD)

// File: eye_tracker_top.f
verilog/video_pkg.sv
verilog/link_pkg.sv
verilog/camera_input.sv
verilog/gravity_accum.sv
verilog/result_sender.sv
verilog/uart_tx.sv
verilog/eye_tracker_top.sv
test/eye_tracker_tb.sv

// File: test/eye_tracker_tb.sv
// Eye tracker testbench driving camera frames and decoding the UART result messages
`timescale 1ns/10ps
`default_nettype none

module eye_tracker_tb;

    localparam int start_timeout = 4000;   // cclk cycles allowed before a start bit
    localparam int max_lines     = 8;
    localparam int max_pixels    = 20;

    logic                              cclk;
    logic                              reset;
    video_pkg::cam_in_t                cam;
    logic [video_pkg::pixel_width-1:0] threshold;
    logic                              uart_txd;

    // Current frame image and its model sums
    logic [7:0]  pix [max_lines][max_pixels];
    int          line_len [max_lines];
    int          n_lines;
    logic [7:0]  thr;
    logic [31:0] exp_s;
    logic [31:0] exp_sx;
    logic [31:0] exp_sy;
    logic [31:0] saved_s;
    logic [31:0] saved_sx;
    logic [31:0] saved_sy;

    eye_tracker_top dut_i (
        .cclk      (cclk),
        .reset     (reset),
        .cam       (cam),
        .threshold (threshold),
        .uart_txd  (uart_txd)
    );

    initial begin
        cclk = 1'b0;
        forever #2 cclk = ~cclk;   // 4 ns period
    end

    // --------------------
    // Error reporting
    // --------------------
    task automatic stop_run();
        $display("Test failed");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic value_error(input string name, input logic [95:0] expected,
                               input logic [95:0] actual);
        $display("[ERROR] %s expected 0x%0h got 0x%0h", name, expected, actual);
        stop_run();
    endtask

    task automatic run_error(input string what);
        $display("%s", what);
        stop_run();
    endtask

    // Advance one clock to 1 ns past the edge
    task automatic next_cycle(input bit expect_idle);
        @(posedge cclk);
        #1;
        if (expect_idle) begin
            assert (uart_txd === 1'b1) else value_error("uart_txd", 1, uart_txd);
        end
    endtask

    function automatic logic [31:0] count_pixels();
        logic [31:0] total;
        total = 0;
        for (int l = 0; l < n_lines; l++) begin
            total = total + 32'(line_len[l]);
        end
        return total;
    endfunction

    // --------------------
    // Frame model and driver
    // --------------------
    // Mode 0 random pixels, 1 equal to threshold, 2 one below threshold
    task automatic build_frame(input int mode, input int lines);
        n_lines = lines;
        exp_s   = 0;
        exp_sx  = 0;
        exp_sy  = 0;
        if (mode == 0) thr = 8'($urandom % 256);
        else thr = 8'(1 + $urandom % 255);   // Leaves room for thr - 1
        for (int l = 0; l < lines; l++) begin
            line_len[l] = int'(4 + $urandom % 17);
            for (int x = 0; x < line_len[l]; x++) begin
                case (mode)
                    0:       pix[l][x] = 8'($urandom);
                    1:       pix[l][x] = thr;
                    default: pix[l][x] = thr - 8'd1;
                endcase
                if (pix[l][x] < thr) begin   // Strictly darker pixel is pupil
                    exp_s  = exp_s + 1;
                    exp_sx = exp_sx + 32'(x);
                    exp_sy = exp_sy + 32'(l);
                end
            end
        end
    endtask

    task automatic drive_frame(input int max_gap, input bit expect_idle);
        int gaps;
        next_cycle(expect_idle);   // Start just after a rising edge
        threshold = thr;
        cam       = '0;
        repeat (2) next_cycle(expect_idle);
        cam.fval = 1'b1;
        repeat (2) next_cycle(expect_idle);
        for (int l = 0; l < n_lines; l++) begin
            cam.lval = 1'b1;
            for (int x = 0; x < line_len[l]; x++) begin
                gaps = int'($urandom % (max_gap + 1));
                repeat (gaps) begin
                    cam.dval = 1'b0;
                    cam.data = 8'($urandom);   // Noise that must not count
                    next_cycle(expect_idle);
                end
                cam.dval = 1'b1;
                cam.data = pix[l][x];
                next_cycle(expect_idle);
            end
            cam.lval = 1'b0;
            cam.dval = 1'b0;
            repeat (1 + $urandom % 3) next_cycle(expect_idle);
        end
        cam.fval = 1'b0;
        next_cycle(1'b0);
    endtask

    // --------------------
    // UART decoding
    // --------------------
    task automatic receive_byte(output link_pkg::byte_t data);
        int waited;
        waited = 0;
        @(negedge cclk);
        while (uart_txd !== 1'b0) begin
            if (waited == start_timeout) begin
                run_error("Timed out waiting for a UART start bit");
            end
            waited++;
            @(negedge cclk);
        end
        repeat (link_pkg::clks_per_bit / 2 - 1) @(negedge cclk);   // Middle of start bit
        assert (uart_txd === 1'b0) else value_error("uart_txd start bit", 0, uart_txd);
        for (int i = 0; i < 8; i++) begin
            repeat (link_pkg::clks_per_bit) @(negedge cclk);
            data[i] = uart_txd;   // LSB first
        end
        repeat (link_pkg::clks_per_bit) @(negedge cclk);
        assert (uart_txd === 1'b1) else value_error("uart_txd stop bit", 1, uart_txd);
    endtask

    task automatic receive_message(input logic [31:0] s, input logic [31:0] sx,
                                   input logic [31:0] sy);
        logic [95:0]     expected;
        link_pkg::byte_t got;
        expected = {link_pkg::msg_header, s[23:0], sx, sy};
        for (int i = 0; i < link_pkg::msg_bytes; i++) begin
            receive_byte(got);
            assert (got === expected[95 - 8*i -: 8])
                else value_error($sformatf("message byte %0d", i), expected[95 - 8*i -: 8], got);
        end
        // Line back to idle after the last stop bit
        repeat (2 * link_pkg::clks_per_bit) begin
            @(negedge cclk);
            assert (uart_txd === 1'b1) else value_error("uart_txd idle", 1, uart_txd);
        end
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        reset     = 1'b1;
        cam       = '0;
        threshold = '0;
        void'($urandom(72225));
        repeat (8) next_cycle(1'b1);
        reset = 1'b0;
        next_cycle(1'b1);

        build_frame(0, 4);          // Random frame with the line idle until it ends
        drive_frame(2, 1'b1);
        receive_message(exp_s, exp_sx, exp_sy);

        build_frame(1, 3);          // Pixels at threshold are not pupil
        drive_frame(1, 1'b1);
        receive_message(32'h0, 32'h0, 32'h0);
        build_frame(2, 3);
        drive_frame(1, 1'b1);
        receive_message(count_pixels(), exp_sx, exp_sy);

        build_frame(0, 5);          // Same image without and with dval gaps
        drive_frame(0, 1'b1);
        receive_message(exp_s, exp_sx, exp_sy);
        drive_frame(3, 1'b1);
        receive_message(exp_s, exp_sx, exp_sy);

        build_frame(0, 4);
        drive_frame(1, 1'b1);
        saved_s  = exp_s;
        saved_sx = exp_sx;
        saved_sy = exp_sy;
        fork
            receive_message(saved_s, saved_sx, saved_sy);
            begin
                build_frame(1, 3);  // Ends mid-message so its result is dropped
                drive_frame(1, 1'b0);
            end
        join
        build_frame(2, 4);
        drive_frame(1, 1'b1);
        receive_message(exp_s, exp_sx, exp_sy);

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/camera_input.sv
// Camera input: registers the Camera Link left tap and tags each pixel with x/y
`timescale 1ns/10ps
`default_nettype none

module camera_input (
    input  wire                    cclk,
    input  wire                    reset,
    input  wire video_pkg::cam_in_t cam,
    output video_pkg::pix_stream_t stream
);

    logic                              fval_q;
    logic                              lval_q;
    logic [video_pkg::coord_width-1:0] x_cnt;
    logic [video_pkg::coord_width-1:0] y_cnt;
    logic                              accept;
    logic                              line_done;

    assign accept    = cam.fval & cam.lval & cam.dval;
    assign line_done = lval_q & ~cam.lval & cam.fval;   // lval falling inside frame

    // Sync history for edge detection
    always_ff @(posedge cclk) begin
        if (reset) begin
            fval_q <= 1'b0;
            lval_q <= 1'b0;
        end else begin
            fval_q <= cam.fval;
            lval_q <= cam.lval;
        end
    end

    // --------------------
    // Coordinate counters
    // --------------------
    always_ff @(posedge cclk) begin
        if (reset) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else if (!cam.fval) begin
            x_cnt <= '0;   // Idle between frames
            y_cnt <= '0;
        end else begin
            if (!cam.lval) begin
                x_cnt <= '0;
            end else if (accept) begin
                x_cnt <= x_cnt + 1;
            end
            if (line_done) begin
                y_cnt <= y_cnt + 1;
            end
        end
    end

    // Stream output, one cycle after the camera inputs
    always_ff @(posedge cclk) begin
        stream.x    <= x_cnt;      // Count before this pixel
        stream.y    <= y_cnt;
        stream.data <= cam.data;
        if (reset) begin
            stream.de        <= 1'b0;
            stream.frame_end <= 1'b0;
        end else begin
            stream.de        <= accept;
            stream.frame_end <= fval_q & ~cam.fval;
        end
    end

endmodule

`default_nettype wire

// File: verilog/eye_tracker_top.sv
// Eye tracker top: camera capture, pupil gravity sums and UART result link
`timescale 1ns/10ps
`default_nettype none

module eye_tracker_top (
    input  wire                              cclk,
    input  wire                              reset,
    input  wire video_pkg::cam_in_t          cam,
    input  wire [video_pkg::pixel_width-1:0] threshold,
    output logic                             uart_txd
);

    video_pkg::pix_stream_t stream;
    video_pkg::gravity_t    result;
    logic                   result_valid;
    logic                   tx_start;
    link_pkg::byte_t        tx_byte;
    logic                   tx_busy;

    // --------------------
    // Capture and gravity
    // --------------------
    camera_input camera_input_i (
        .cclk   (cclk),
        .reset  (reset),
        .cam    (cam),
        .stream (stream)
    );

    gravity_accum gravity_accum_i (
        .cclk         (cclk),
        .reset        (reset),
        .stream       (stream),
        .threshold    (threshold),
        .result       (result),
        .result_valid (result_valid)
    );

    // --------------------
    // Result link
    // --------------------
    result_sender result_sender_i (
        .cclk         (cclk),
        .reset        (reset),
        .result       (result),
        .result_valid (result_valid),   // Ignored while a message is out
        .tx_busy      (tx_busy),
        .tx_start     (tx_start),
        .tx_byte      (tx_byte)
    );

    uart_tx uart_tx_i (
        .cclk     (cclk),
        .reset    (reset),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .tx_busy  (tx_busy),
        .txd      (uart_txd)
    );

endmodule

`default_nettype wire

// File: verilog/gravity_accum.sv
// Gravity accumulator: binarizes pixels and sums count, x and y per frame
`timescale 1ns/10ps
`default_nettype none

module gravity_accum (
    input  wire                              cclk,
    input  wire                              reset,
    input  wire video_pkg::pix_stream_t      stream,
    input  wire [video_pkg::pixel_width-1:0] threshold,
    output video_pkg::gravity_t              result,
    output logic                             result_valid
);

    logic [video_pkg::sum_s_width-1:0]  sum_s;
    logic [video_pkg::sum_sx_width-1:0] sum_sx;
    logic [video_pkg::sum_sy_width-1:0] sum_sy;
    logic [video_pkg::sum_sx_width-1:0] x_ext;
    logic [video_pkg::sum_sy_width-1:0] y_ext;
    logic                               pupil;

    // Dark pixel, strictly below threshold
    assign pupil = stream.de & (stream.data < threshold);

    // Zero-extend coordinates to accumulator width
    assign x_ext = {{(video_pkg::sum_sx_width - video_pkg::coord_width){1'b0}}, stream.x};
    assign y_ext = {{(video_pkg::sum_sy_width - video_pkg::coord_width){1'b0}}, stream.y};

    // --------------------
    // Frame accumulators
    // --------------------
    always_ff @(posedge cclk) begin
        if (reset) begin
            sum_s        <= '0;
            sum_sx       <= '0;
            sum_sy       <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= stream.frame_end;
            if (stream.frame_end) begin
                sum_s  <= '0;           // Ready for next frame
                sum_sx <= '0;
                sum_sy <= '0;
            end else if (pupil) begin
                sum_s  <= sum_s + 1;
                sum_sx <= sum_sx + x_ext;
                sum_sy <= sum_sy + y_ext;
            end
        end
    end

    // Result snapshot, valid with result_valid
    always_ff @(posedge cclk) begin
        if (stream.frame_end) begin
            result.sum_s  <= sum_s;
            result.sum_sx <= sum_sx;
            result.sum_sy <= sum_sy;
        end
    end

endmodule

`default_nettype wire

// File: verilog/link_pkg.sv
// Link package: UART bit timing and result message format
`default_nettype none

package link_pkg;

    // --------------------
    // Serial timing
    // --------------------
    localparam int clks_per_bit = 8;    // Bit period in cclk cycles

    // --------------------
    // Message format
    // --------------------
    localparam logic [7:0] msg_header = 8'hA5;
    localparam int         msg_bytes  = 12;   // Header + 3 + 4 + 4

    typedef logic [7:0] byte_t;

endpackage

`default_nettype wire

// File: verilog/result_sender.sv
// Result sender: turns one frame result into the 12-byte UART message
`timescale 1ns/10ps
`default_nettype none

module result_sender (
    input  wire                  cclk,
    input  wire                  reset,
    input  wire video_pkg::gravity_t result,
    input  wire                  result_valid,
    input  wire                  tx_busy,
    output logic                 tx_start,
    output link_pkg::byte_t      tx_byte
);

    logic [link_pkg::msg_bytes*8-1:0] msg;        // Remaining bytes, MSB first
    logic [3:0]                       byte_idx;   // Bytes handed to the UART
    logic                             active;
    logic                             tx_free;
    logic                             load;
    logic                             send;

    // UART idle and no strobe in flight
    assign tx_free = ~tx_start & ~tx_busy;
    assign load    = ~active & result_valid;      // Dropped while active
    assign send    = active & tx_free & (byte_idx != link_pkg::msg_bytes);

    // --------------------
    // Message control
    // --------------------
    always_ff @(posedge cclk) begin
        if (reset) begin
            active   <= 1'b0;
            byte_idx <= '0;
            tx_start <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            if (load) begin
                active   <= 1'b1;
                byte_idx <= '0;
            end else if (send) begin
                tx_start <= 1'b1;
                byte_idx <= byte_idx + 1;
            end else if (active && tx_free) begin
                active <= 1'b0;   // Last stop bit done
            end
        end
    end

    // Message word, sums zero-extended to whole bytes
    always_ff @(posedge cclk) begin
        if (load) begin
            msg <= {link_pkg::msg_header,
                    {(24 - video_pkg::sum_s_width){1'b0}}, result.sum_s,
                    {(32 - video_pkg::sum_sx_width){1'b0}}, result.sum_sx,
                    {(32 - video_pkg::sum_sy_width){1'b0}}, result.sum_sy};
        end else if (send) begin
            tx_byte <= msg[link_pkg::msg_bytes*8-1 -: 8];
            msg     <= msg << 8;
        end
    end

endmodule

`default_nettype wire

// File: verilog/uart_tx.sv
// UART transmitter: 8N1 serial output with the bit period counted in cclk cycles
`timescale 1ns/10ps
`default_nettype none

module uart_tx (
    input  wire             cclk,
    input  wire             reset,
    input  wire             tx_start,
    input  wire link_pkg::byte_t tx_byte,
    output logic            tx_busy,
    output logic            txd
);

    logic [9:0]                                 shifter;   // Stop, data, start
    logic [3:0]                                 bit_cnt;
    logic [$clog2(link_pkg::clks_per_bit)-1:0]  clk_cnt;

    assign txd = shifter[0];   // Idles high through the stop-bit fill

    always_ff @(posedge cclk) begin
        if (reset) begin
            shifter <= '1;
            bit_cnt <= '0;
            clk_cnt <= '0;
            tx_busy <= 1'b0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                shifter <= {1'b1, tx_byte, 1'b0};
                bit_cnt <= '0;
                clk_cnt <= '0;
                tx_busy <= 1'b1;
            end
        end else begin
            // --------------------
            // Bit period timing
            // --------------------
            if (clk_cnt == link_pkg::clks_per_bit - 1) begin
                clk_cnt <= '0;
                shifter <= {1'b1, shifter[9:1]};   // LSB first
                if (bit_cnt == 4'd9) begin
                    tx_busy <= 1'b0;               // Stop bit finished
                end else begin
                    bit_cnt <= bit_cnt + 1;
                end
            end else begin
                clk_cnt <= clk_cnt + 1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/video_pkg.sv
// Video package: camera-side constants and the pixel stream and result types
`default_nettype none

package video_pkg;

    localparam int pixel_width  = 8;
    localparam int coord_width  = 10;   // Covers 640 columns, 480 rows
    localparam int sum_s_width  = 20;
    localparam int sum_sx_width = 28;
    localparam int sum_sy_width = 28;

    // Raw Camera Link bundle, left tap only
    typedef struct packed {
        logic                   fval;
        logic                   lval;
        logic                   dval;
        logic [pixel_width-1:0] data;
    } cam_in_t;

    // Conditioned pixel stream
    typedef struct packed {
        logic                   de;          // One accepted pixel
        logic                   frame_end;   // Pulse after fval falls
        logic [coord_width-1:0] x;
        logic [coord_width-1:0] y;
        logic [pixel_width-1:0] data;
    } pix_stream_t;

    // One frame's gravity sums
    typedef struct packed {
        logic [sum_s_width-1:0]  sum_s;
        logic [sum_sx_width-1:0] sum_sx;
        logic [sum_sy_width-1:0] sum_sy;
    } gravity_t;

endpackage

`default_nettype wire
